// ==== hw/cache_addr_pkg.sv ====
`default_nettype none

package cache_addr_pkg;

  // byte address split into tag, set index and byte offset
  localparam int addr_width = 32;
  localparam int offset_width = 2;
  localparam int set_width = 7;
  localparam int tag_width = addr_width - set_width - offset_width;

  // msb first, so tag sits on top and offset at the bottom
  typedef struct packed {
    logic [tag_width-1:0]    tag;
    logic [set_width-1:0]    set_idx;
    logic [offset_width-1:0] offset;
  } addr_fields_t;

  // one address word seen either whole or as fields
  typedef union packed {
    logic [addr_width-1:0] raw;
    addr_fields_t          fields;
  } addr_u;

endpackage

`default_nettype wire

// ==== hw/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // cache geometry
  localparam int line_bytes = 4;
  localparam int cache_bytes = 1024;
  localparam int way_num = 2;

  // 1024 / 4 / 2 = 128 sets
  localparam int set_num = cache_bytes / line_bytes / way_num;

  // one word per line
  localparam int data_width = line_bytes * 8;

  // width of a way select, also the size of the per-set lru field
  localparam int way_sel_width = $clog2(way_num);

endpackage

`default_nettype wire

// ==== hw/bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bram #(
  parameter int data_width = 32,
  parameter int depth = 128
) (
  input  wire                      clk,
  input  wire [$clog2(depth)-1:0]  addr,
  input  wire                      wen,
  input  wire [data_width-1:0]     din,
  output logic [data_width-1:0]    dout
);

  // storage, no reset like a real block ram
  logic [data_width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (wen) begin
      mem[addr] <= din;
    end
  end

  // registered read, returns the old word when written in the same cycle
  always_ff @(posedge clk) begin
    dout <= mem[addr];
  end

endmodule

`default_nettype wire

// ==== hw/lru_replacer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lru_replacer (
  input  wire                                    clk,
  input  wire                                    reset,
  input  wire                                    fill_valid,
  input  wire [cache_addr_pkg::set_width-1:0]    fill_set,
  input  wire [cache_pkg::way_num-1:0]           fill_match,
  input  wire                                    hit_valid,
  input  wire [cache_addr_pkg::set_width-1:0]    hit_set,
  input  wire [cache_pkg::way_sel_width-1:0]     hit_way,
  output logic [cache_pkg::way_sel_width-1:0]    victim_way,
  output logic [cache_pkg::way_num-1:0]          hit_set_valid
);

  // per set line valid bits
  logic [cache_pkg::set_num-1:0][cache_pkg::way_num-1:0] valid_q;
  // per set index of the most recently used way
  logic [cache_pkg::set_num-1:0][cache_pkg::way_sel_width-1:0] mru_q;

  logic [cache_pkg::way_num-1:0] fill_set_valid;
  logic [cache_pkg::way_num-1:0] fill_hit;

  assign fill_set_valid = valid_q[fill_set];

  // shadow tag compare only counts on valid lines
  assign fill_hit = fill_match & fill_set_valid;

  // valid bits of the set being answered
  assign hit_set_valid = valid_q[hit_set];

  // victim: matching way, then first invalid way, then least recently used
  always_comb begin
    if (fill_hit[0]) begin
      victim_way = '0;
    end else if (fill_hit[1]) begin
      victim_way = '1;
    end else if (!fill_set_valid[0]) begin
      victim_way = '0;
    end else if (!fill_set_valid[1]) begin
      victim_way = '1;
    end else begin
      victim_way = ~mru_q[fill_set];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      mru_q   <= '0;
    end else begin
      if (hit_valid) begin
        mru_q[hit_set] <= hit_way;
      end
      // fill comes last so it wins on a shared set
      if (fill_valid) begin
        valid_q[fill_set][victim_way] <= 1'b1;
        mru_q[fill_set]               <= victim_way;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/set_associative.sv ====
`timescale 1ns/1ps
`default_nettype none

module set_associative (
  input  wire                                  clk,
  input  wire                                  reset,

  input  wire                                  req_valid,
  output logic                                 req_ready,
  input  wire [cache_addr_pkg::addr_width-1:0] req_addr,

  output logic                                 resp_valid,
  output logic                                 resp_hit,
  output logic [cache_pkg::data_width-1:0]     resp_data,

  input  wire                                  fill_valid,
  input  wire [cache_addr_pkg::addr_width-1:0] fill_addr,
  input  wire [cache_pkg::data_width-1:0]      fill_data
);

  cache_addr_pkg::addr_u req_word;
  cache_addr_pkg::addr_u fill_word;

  logic [cache_addr_pkg::tag_width-1:0] req_tag;
  logic [cache_addr_pkg::set_width-1:0] req_set;
  logic [cache_addr_pkg::tag_width-1:0] fill_tag;
  logic [cache_addr_pkg::set_width-1:0] fill_set;

  // offset field is decoded but not needed with one word per line
  assign req_word.raw  = req_addr;
  assign fill_word.raw = fill_addr;

  assign req_tag  = req_word.fields.tag;
  assign req_set  = req_word.fields.set_idx;
  assign fill_tag = fill_word.fields.tag;
  assign fill_set = fill_word.fields.set_idx;

  // fills own the single array port
  logic accept;
  logic [cache_addr_pkg::set_width-1:0] arr_set;

  assign req_ready = ~fill_valid;
  assign accept    = req_valid & req_ready;
  assign arr_set   = fill_valid ? fill_set : req_set;

  // request held for the response cycle
  logic                                 accept_q;
  logic [cache_addr_pkg::tag_width-1:0] req_tag_q;
  logic [cache_addr_pkg::set_width-1:0] req_set_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      accept_q <= 1'b0;
    end else begin
      accept_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      req_tag_q <= req_tag;
      req_set_q <= req_set;
    end
  end

  logic [cache_pkg::way_sel_width-1:0] victim_way;
  logic [cache_pkg::way_num-1:0]       hit_set_valid;
  logic [cache_pkg::way_num-1:0]       fill_match;
  logic [cache_pkg::way_num-1:0]       tag_match;
  logic [cache_pkg::way_sel_width-1:0] hit_way;
  logic                                hit;

  logic [cache_pkg::way_num-1:0][cache_addr_pkg::tag_width-1:0] tag_out;
  logic [cache_pkg::way_num-1:0][cache_pkg::data_width-1:0]     data_out;

  // tag copy in flops, read in the fill cycle for the match check
  logic [cache_addr_pkg::tag_width-1:0] shadow_tag [cache_pkg::way_num][cache_pkg::set_num];

  always_ff @(posedge clk) begin
    if (fill_valid) begin
      shadow_tag[victim_way][fill_set] <= fill_tag;
    end
  end

  genvar w;
  generate
    for (w = 0; w < cache_pkg::way_num; w++) begin : g_way
      logic way_wen;

      assign way_wen       = fill_valid && (victim_way == w);
      assign fill_match[w] = (shadow_tag[w][fill_set] == fill_tag);

      bram #(
        .data_width(cache_addr_pkg::tag_width),
        .depth(cache_pkg::set_num)
      ) u_tag (
        .clk(clk),
        .addr(arr_set),
        .wen(way_wen),
        .din(fill_tag),
        .dout(tag_out[w])
      );

      bram #(
        .data_width(cache_pkg::data_width),
        .depth(cache_pkg::set_num)
      ) u_data (
        .clk(clk),
        .addr(arr_set),
        .wen(way_wen),
        .din(fill_data),
        .dout(data_out[w])
      );

      // compare against the registered request tag
      assign tag_match[w] = hit_set_valid[w] && (tag_out[w] == req_tag_q);
    end
  endgenerate

  // at most one way can match, way 1 checked first
  assign hit_way = tag_match[1] ? '1 : '0;
  assign hit     = accept_q & (|tag_match);

  assign resp_valid = accept_q;
  assign resp_hit   = hit;
  assign resp_data  = hit ? data_out[hit_way] : '0;

  lru_replacer u_lru (
    .clk(clk),
    .reset(reset),
    .fill_valid(fill_valid),
    .fill_set(fill_set),
    .fill_match(fill_match),
    .hit_valid(hit),
    .hit_set(req_set_q),
    .hit_way(hit_way),
    .victim_way(victim_way),
    .hit_set_valid(hit_set_valid)
  );

endmodule

`default_nettype wire

// ==== hw/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top (
  input  wire                                  clk,
  input  wire                                  reset,

  // lookup request
  input  wire                                  req_valid,
  output logic                                 req_ready,
  input  wire [cache_addr_pkg::addr_width-1:0] req_addr,

  // one cycle after the request is taken
  output logic                                 resp_valid,
  output logic                                 resp_hit,
  output logic [cache_pkg::data_width-1:0]     resp_data,

  // refill, always accepted
  input  wire                                  fill_valid,
  input  wire [cache_addr_pkg::addr_width-1:0] fill_addr,
  input  wire [cache_pkg::data_width-1:0]      fill_data
);

  set_associative u_cache (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_addr(req_addr),
    .resp_valid(resp_valid),
    .resp_hit(resp_hit),
    .resp_data(resp_data),
    .fill_valid(fill_valid),
    .fill_addr(fill_addr),
    .fill_data(fill_data)
  );

endmodule

`default_nettype wire

// ==== dv/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  localparam int table_len = 17;
  localparam int random_ops = 300;
  localparam int timeout_cycles = 50;

  logic        clk;
  logic        reset;
  logic        req_valid;
  logic        req_ready;
  logic [31:0] req_addr;
  logic        resp_valid;
  logic        resp_hit;
  logic [31:0] resp_data;
  logic        fill_valid;
  logic [31:0] fill_addr;
  logic [31:0] fill_data;

  typedef struct packed {
    logic        is_fill;
    logic [31:0] addr;
    logic [31:0] data;
    logic        exp_hit;
    logic [31:0] exp_data;
  } op_t;

  op_t op_table [table_len];

  // reference model, one entry per set and way
  logic        m_valid [128][2];
  logic [22:0] m_tag [128][2];
  logic [31:0] m_data [128][2];
  logic        m_mru [128];

  integer seed = 21485;
  int error_count = 0;
  int start_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  cache_top uut (
    .clk(clk),
    .reset(reset),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req_addr(req_addr),
    .resp_valid(resp_valid),
    .resp_hit(resp_hit),
    .resp_data(resp_data),
    .fill_valid(fill_valid),
    .fill_addr(fill_addr),
    .fill_data(fill_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] make_addr(input logic [22:0] tag, input logic [6:0] set,
                                            input logic [1:0] off);
    return {tag, set, off};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      error_count++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic abort_run(input string reason);
    error_count++;
    $display("%s (time %0t)", reason, $time);
    $display("Test failed");
    $finish;
  endtask

  task automatic end_test(input string name);
    if (error_count == start_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d mismatches", name, error_count - start_errors);
    end
    start_errors = error_count;
  endtask

  // matching valid way, then lowest invalid way, then the way not used last
  task automatic model_fill(input logic [31:0] addr, input logic [31:0] data);
    logic [6:0]  set;
    logic [22:0] tag;
    logic        way;
    set = addr[8:2];
    tag = addr[31:9];
    if (m_valid[set][0] && m_tag[set][0] == tag) way = 1'b0;
    else if (m_valid[set][1] && m_tag[set][1] == tag) way = 1'b1;
    else if (!m_valid[set][0]) way = 1'b0;
    else if (!m_valid[set][1]) way = 1'b1;
    else way = ~m_mru[set];
    m_valid[set][way] = 1'b1;
    m_tag[set][way] = tag;
    m_data[set][way] = data;
    m_mru[set] = way;
  endtask

  task automatic model_lookup(input logic [31:0] addr, output logic hit, output logic [31:0] data);
    logic [6:0]  set;
    logic [22:0] tag;
    set = addr[8:2];
    tag = addr[31:9];
    hit = 1'b0;
    data = '0;
    for (int w = 0; w < 2; w++) begin
      if (m_valid[set][w] && m_tag[set][w] == tag) begin
        hit = 1'b1;
        data = m_data[set][w];
        m_mru[set] = w[0];
      end
    end
  endtask

  task automatic do_fill(input logic [31:0] addr, input logic [31:0] data);
    fill_valid = 1'b1;
    fill_addr = addr;
    fill_data = data;
    model_fill(addr, data);
    @(posedge clk);
    #1;
    fill_valid = 1'b0;
  endtask

  // ends one cycle after the response so the lru update has landed
  task automatic do_lookup(input logic [31:0] addr, input logic exp_hit,
                           input logic [31:0] exp_data);
    int waited;
    req_valid = 1'b1;
    req_addr = addr;
    waited = 0;
    @(negedge clk);
    check_value("resp_valid", 32'd0, resp_valid);
    while (!req_ready) begin
      if (waited >= timeout_cycles) abort_run("req_ready never rose for a lookup");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!resp_valid) begin
      if (waited >= timeout_cycles) abort_run("no response arrived for an accepted lookup");
      waited++;
      @(negedge clk);
    end
    check_value("resp_hit", exp_hit, resp_hit);
    check_value("resp_data", exp_data, resp_data);
    @(posedge clk);
    #1;
  endtask

  task automatic set_row(input int idx, input logic is_fill, input logic [31:0] addr,
                         input logic [31:0] data, input logic hit, input logic [31:0] exp);
    op_table[idx] = '{is_fill, addr, data, hit, exp};
  endtask

  task automatic load_table();
    // cold cache misses
    set_row(0, 1'b0, make_addr(23'h5, 7'd3, 2'd0), 32'h0, 1'b0, 32'h0);
    set_row(1, 1'b0, make_addr(23'h7fffff, 7'd127, 2'd3), 32'h0, 1'b0, 32'h0);
    // fill then hit, other tag misses
    set_row(2, 1'b1, make_addr(23'h10, 7'd5, 2'd0), 32'ha5a5_0001, 1'b0, 32'h0);
    set_row(3, 1'b0, make_addr(23'h10, 7'd5, 2'd2), 32'h0, 1'b1, 32'ha5a5_0001);
    set_row(4, 1'b0, make_addr(23'h11, 7'd5, 2'd0), 32'h0, 1'b0, 32'h0);
    // both ways of set 9, then lru eviction of tag 0x21
    set_row(5, 1'b1, make_addr(23'h20, 7'd9, 2'd0), 32'h1111_0000, 1'b0, 32'h0);
    set_row(6, 1'b1, make_addr(23'h21, 7'd9, 2'd0), 32'h2222_0000, 1'b0, 32'h0);
    set_row(7, 1'b0, make_addr(23'h20, 7'd9, 2'd1), 32'h0, 1'b1, 32'h1111_0000);
    set_row(8, 1'b0, make_addr(23'h21, 7'd9, 2'd0), 32'h0, 1'b1, 32'h2222_0000);
    set_row(9, 1'b0, make_addr(23'h20, 7'd9, 2'd0), 32'h0, 1'b1, 32'h1111_0000);
    set_row(10, 1'b1, make_addr(23'h22, 7'd9, 2'd0), 32'h3333_0000, 1'b0, 32'h0);
    set_row(11, 1'b0, make_addr(23'h21, 7'd9, 2'd0), 32'h0, 1'b0, 32'h0);
    set_row(12, 1'b0, make_addr(23'h20, 7'd9, 2'd0), 32'h0, 1'b1, 32'h1111_0000);
    set_row(13, 1'b0, make_addr(23'h22, 7'd9, 2'd3), 32'h0, 1'b1, 32'h3333_0000);
    // refill of a present tag stays in its way
    set_row(14, 1'b1, make_addr(23'h20, 7'd9, 2'd0), 32'h4444_0000, 1'b0, 32'h0);
    set_row(15, 1'b0, make_addr(23'h20, 7'd9, 2'd0), 32'h0, 1'b1, 32'h4444_0000);
    set_row(16, 1'b0, make_addr(23'h22, 7'd9, 2'd0), 32'h0, 1'b1, 32'h3333_0000);
  endtask

  task automatic apply_rows(input int first, input int last);
    logic        hit;
    logic [31:0] data;
    for (int i = first; i <= last; i++) begin
      if (op_table[i].is_fill) begin
        do_fill(op_table[i].addr, op_table[i].data);
      end else begin
        // keeps the model lru in step with the dut
        model_lookup(op_table[i].addr, hit, data);
        do_lookup(op_table[i].addr, op_table[i].exp_hit, op_table[i].exp_data);
      end
    end
  endtask

  task automatic run_backpressure();
    int          waited;
    logic        hit;
    logic [31:0] data;
    logic [31:0] seq [4];
    // request stays up while three fills own the array port
    req_valid = 1'b1;
    req_addr = make_addr(23'h3, 7'd40, 2'd0);
    for (int i = 0; i < 3; i++) begin
      fill_valid = 1'b1;
      fill_addr = make_addr(23'h3, 7'd40 + i[6:0], 2'd0);
      fill_data = 32'hbeef_0000 + i;
      model_fill(fill_addr, fill_data);
      @(negedge clk);
      check_value("req_ready", 32'd0, req_ready);
      check_value("resp_valid", 32'd0, resp_valid);
      @(posedge clk);
      #1;
    end
    fill_valid = 1'b0;
    model_lookup(req_addr, hit, data);
    waited = 0;
    @(negedge clk);
    while (!req_ready) begin
      if (waited >= timeout_cycles) abort_run("req_ready stayed low after the fills ended");
      waited++;
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    waited = 0;
    @(negedge clk);
    while (!resp_valid) begin
      if (waited >= timeout_cycles) abort_run("no response after back-pressure");
      waited++;
      @(negedge clk);
    end
    check_value("resp_hit", hit, resp_hit);
    check_value("resp_data", data, resp_data);
    @(posedge clk);
    #1;
    // back to back, one response per cycle in order
    seq[0] = make_addr(23'h20, 7'd9, 2'd0);
    seq[1] = make_addr(23'h99, 7'd9, 2'd0);
    seq[2] = make_addr(23'h10, 7'd5, 2'd0);
    seq[3] = make_addr(23'h22, 7'd9, 2'd0);
    req_valid = 1'b1;
    req_addr = seq[0];
    @(negedge clk);
    for (int i = 0; i < 4; i++) begin
      check_value("req_ready", 32'd1, req_ready);
      @(posedge clk);
      #1;
      if (i < 3) req_addr = seq[i + 1];
      else req_valid = 1'b0;
      model_lookup(seq[i], hit, data);
      @(negedge clk);
      check_value("resp_valid", 32'd1, resp_valid);
      check_value("resp_hit", hit, resp_hit);
      check_value("resp_data", data, resp_data);
    end
    @(negedge clk);
    check_value("resp_valid", 32'd0, resp_valid);
    @(posedge clk);
    #1;
  endtask

  // few sets and few tags so ways get evicted often
  task automatic run_random();
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] data;
    logic        hit;
    for (int n = 0; n < random_ops; n++) begin
      r = $random(seed);
      addr = make_addr({21'd0, r[1:0]}, 7'd20 + {5'd0, r[3:2]}, r[5:4]);
      if (r[8]) begin
        do_fill(addr, $random(seed));
      end else begin
        model_lookup(addr, hit, data);
        do_lookup(addr, hit, data);
      end
    end
  endtask

  initial begin
    reset = 1'b1;
    req_valid = 1'b0;
    req_addr = '0;
    fill_valid = 1'b0;
    fill_addr = '0;
    fill_data = '0;
    for (int s = 0; s < 128; s++) begin
      m_valid[s][0] = 1'b0;
      m_valid[s][1] = 1'b0;
      m_mru[s] = 1'b0;
    end
    load_table();
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    // idle, nothing accepted so nothing answered
    repeat (4) begin
      @(negedge clk);
      check_value("resp_valid", 32'd0, resp_valid);
    end
    @(posedge clk);
    #1;
    apply_rows(0, 1);
    end_test("reset and cold misses");
    apply_rows(2, 4);
    end_test("fill then lookup");
    apply_rows(5, 13);
    end_test("lru eviction");
    apply_rows(14, 16);
    end_test("refill in place");
    run_backpressure();
    end_test("back-pressure and streaming");
    run_random();
    end_test("random mix");

    $display("%0d tests passed, %0d tests failed, %0d mismatches",
             tests_passed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/cache_addr_pkg.sv
hw/cache_pkg.sv
hw/bram.sv
hw/lru_replacer.sv
hw/set_associative.sv
hw/cache_top.sv
dv/cache_tb.sv
